// File: Makefile
# Verilator build for the RV32I subset pipeline

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status of the simulation binary is the verdict
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: common/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// datapath width
`define RV_XLEN 32

// register file: number of registers follows the register-number width
`define RV_REGNO_W 5
`define RV_NUM_REGS (1 << `RV_REGNO_W)

// instruction memory, word addressed
`define RV_IMEM_AW 6
`define RV_IMEM_DEPTH (1 << `RV_IMEM_AW)

// instruction field widths
`define RV_OPC_W 7
`define RV_F3_W 3
`define RV_F7_W 7

`endif

// File: common/rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]    word_t;
  typedef logic [31:0]            inst_t;
  typedef logic [`RV_REGNO_W-1:0] regno_t;
  typedef logic [`RV_IMEM_AW-1:0] pc_t;

  // internal opcode handed from decode to the ALU
  typedef enum logic [3:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
  } alu_op_e;

  // format class, picks operand sources and which sources the scoreboard checks
  typedef enum logic [1:0] {
    FMT_R, FMT_I, FMT_U, FMT_INVALID
  } inst_fmt_e;

  typedef enum logic {
    FETCH_IDLE, FETCH_RUN
  } fetch_state_e;

  // major opcodes
  parameter logic [`RV_OPC_W-1:0] OPC_OP     = 7'b0110011;
  parameter logic [`RV_OPC_W-1:0] OPC_OP_IMM = 7'b0010011;
  parameter logic [`RV_OPC_W-1:0] OPC_LUI    = 7'b0110111;

  // funct3 values shared by OP and OP-IMM
  parameter logic [`RV_F3_W-1:0] F3_ADD_SUB = 3'b000;
  parameter logic [`RV_F3_W-1:0] F3_SLL     = 3'b001;
  parameter logic [`RV_F3_W-1:0] F3_SLT     = 3'b010;
  parameter logic [`RV_F3_W-1:0] F3_SLTU    = 3'b011;
  parameter logic [`RV_F3_W-1:0] F3_XOR     = 3'b100;
  parameter logic [`RV_F3_W-1:0] F3_SRL_SRA = 3'b101;
  parameter logic [`RV_F3_W-1:0] F3_OR      = 3'b110;
  parameter logic [`RV_F3_W-1:0] F3_AND     = 3'b111;

  // funct7: base encoding and the SUB / SRA variant
  parameter logic [`RV_F7_W-1:0] F7_BASE = 7'b0000000;
  parameter logic [`RV_F7_W-1:0] F7_ALT  = 7'b0100000;

endpackage

// File: decode/decode_stage.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module decode_stage (
  input  logic              clk,
  input  logic              reset,
  input  logic              fetch_valid,
  input  rv_pkg::inst_t     fetch_inst,
  input  logic              wb_valid,
  input  rv_pkg::regno_t    wb_regno,
  input  rv_pkg::word_t     wb_value,
  output logic              stall,
  output logic              dec_valid,
  output rv_pkg::alu_op_e   dec_op,
  output rv_pkg::regno_t    dec_rd,
  output logic              dec_wen,
  output rv_pkg::word_t     dec_opa,
  output rv_pkg::word_t     dec_opb
);

  rv_pkg::word_t regs [`RV_NUM_REGS];
  logic [`RV_NUM_REGS-1:0] busy;  // one bit per register with a write in flight

  logic [`RV_OPC_W-1:0] opcode;
  logic [`RV_F3_W-1:0]  funct3;
  logic [`RV_F7_W-1:0]  funct7;
  rv_pkg::regno_t       rs1;
  rv_pkg::regno_t       rs2;
  rv_pkg::regno_t       rd;

  rv_pkg::alu_op_e   op;
  rv_pkg::inst_fmt_e fmt;
  rv_pkg::word_t     imm_i;
  rv_pkg::word_t     imm_u;
  rv_pkg::word_t     rs1_val;
  rv_pkg::word_t     rs2_val;
  rv_pkg::word_t     opa;
  rv_pkg::word_t     opb;

  logic rs1_busy;
  logic rs2_busy;
  logic hazard;
  logic issue;
  logic writes_rd;

  // instruction fields
  assign opcode = fetch_inst[6:0];
  assign rd     = fetch_inst[11:7];
  assign funct3 = fetch_inst[14:12];
  assign rs1    = fetch_inst[19:15];
  assign rs2    = fetch_inst[24:20];
  assign funct7 = fetch_inst[31:25];

  assign imm_i = {{20{fetch_inst[31]}}, fetch_inst[31:20]};  // sign extended
  assign imm_u = {fetch_inst[31:12], 12'b0};

  // opcode / funct match into the internal opcode and format
  always_comb begin
    op  = rv_pkg::ALU_NOP;
    fmt = rv_pkg::FMT_INVALID;
    case (opcode)
      rv_pkg::OPC_OP: begin
        if (funct7 == rv_pkg::F7_BASE) begin
          case (funct3)
            rv_pkg::F3_ADD_SUB: op = rv_pkg::ALU_ADD;
            rv_pkg::F3_SLL:     op = rv_pkg::ALU_SLL;
            rv_pkg::F3_SLT:     op = rv_pkg::ALU_SLT;
            rv_pkg::F3_SLTU:    op = rv_pkg::ALU_SLTU;
            rv_pkg::F3_XOR:     op = rv_pkg::ALU_XOR;
            rv_pkg::F3_SRL_SRA: op = rv_pkg::ALU_SRL;
            rv_pkg::F3_OR:      op = rv_pkg::ALU_OR;
            rv_pkg::F3_AND:     op = rv_pkg::ALU_AND;
            default:            op = rv_pkg::ALU_NOP;
          endcase
        end else if (funct7 == rv_pkg::F7_ALT) begin
          if (funct3 == rv_pkg::F3_ADD_SUB)
            op = rv_pkg::ALU_SUB;
          else if (funct3 == rv_pkg::F3_SRL_SRA)
            op = rv_pkg::ALU_SRA;
        end
        if (op != rv_pkg::ALU_NOP)
          fmt = rv_pkg::FMT_R;
      end
      rv_pkg::OPC_OP_IMM: begin
        case (funct3)
          rv_pkg::F3_ADD_SUB: op = rv_pkg::ALU_ADD;
          rv_pkg::F3_SLT:     op = rv_pkg::ALU_SLT;
          rv_pkg::F3_SLTU:    op = rv_pkg::ALU_SLTU;
          rv_pkg::F3_XOR:     op = rv_pkg::ALU_XOR;
          rv_pkg::F3_OR:      op = rv_pkg::ALU_OR;
          rv_pkg::F3_AND:     op = rv_pkg::ALU_AND;
          rv_pkg::F3_SLL: begin
            if (funct7 == rv_pkg::F7_BASE)
              op = rv_pkg::ALU_SLL;
          end
          rv_pkg::F3_SRL_SRA: begin
            if (funct7 == rv_pkg::F7_BASE)
              op = rv_pkg::ALU_SRL;
            else if (funct7 == rv_pkg::F7_ALT)
              op = rv_pkg::ALU_SRA;
          end
          default: op = rv_pkg::ALU_NOP;
        endcase
        if (op != rv_pkg::ALU_NOP)
          fmt = rv_pkg::FMT_I;
      end
      rv_pkg::OPC_LUI: begin
        op  = rv_pkg::ALU_LUI;
        fmt = rv_pkg::FMT_U;
      end
      default: begin  // loads, stores, branches, system etc. become bubbles
        op  = rv_pkg::ALU_NOP;
        fmt = rv_pkg::FMT_INVALID;
      end
    endcase
  end

  // register read, x0 hardwired to zero
  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

  always_comb begin
    case (fmt)
      rv_pkg::FMT_R: begin
        opa = rs1_val;
        opb = rs2_val;
      end
      rv_pkg::FMT_I: begin
        opa = rs1_val;
        opb = imm_i;
      end
      rv_pkg::FMT_U: begin
        opa = '0;
        opb = imm_u;
      end
      default: begin
        opa = '0;
        opb = '0;
      end
    endcase
  end

  // scoreboard check, only on sources the format reads
  assign rs1_busy = (rs1 != '0) && busy[rs1];
  assign rs2_busy = (rs2 != '0) && busy[rs2];

  always_comb begin
    case (fmt)
      rv_pkg::FMT_R: hazard = rs1_busy || rs2_busy;
      rv_pkg::FMT_I: hazard = rs1_busy;
      default:       hazard = 1'b0;
    endcase
  end

  assign stall     = fetch_valid && hazard;
  assign issue     = fetch_valid && !hazard;
  assign writes_rd = (fmt != rv_pkg::FMT_INVALID);

  // busy bits: the set is written last so it wins over a same-cycle clear
  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (wb_valid)
        busy[wb_regno] <= 1'b0;
      if (issue && writes_rd && (rd != '0))
        busy[rd] <= 1'b1;
    end
  end

  // register file write at the end of the writeback cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_NUM_REGS; i++)
        regs[i] <= '0;
    end else if (wb_valid && (wb_regno != '0)) begin
      regs[wb_regno] <= wb_value;
    end
  end

  // decode latch, a stall or an invalid word leaves a bubble
  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
      dec_wen   <= 1'b0;
    end else begin
      dec_valid <= issue && writes_rd;
      dec_wen   <= issue && writes_rd;
    end
  end

  always_ff @(posedge clk) begin
    dec_op  <= op;
    dec_rd  <= rd;
    dec_opa <= opa;
    dec_opb <= opb;
  end

endmodule

// File: sources.f
+incdir+common
common/rv_pkg.sv
src/fetch_stage.sv
decode/decode_stage.sv
src/execute_stage.sv
src/rv_core_top.sv
tb/rv_core_tb.sv

// File: src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic              clk,
  input  logic              reset,
  input  logic              dec_valid,
  input  rv_pkg::alu_op_e   dec_op,
  input  rv_pkg::regno_t    dec_rd,
  input  logic              dec_wen,
  input  rv_pkg::word_t     dec_opa,
  input  rv_pkg::word_t     dec_opb,
  output logic              wb_valid,
  output rv_pkg::regno_t    wb_regno,
  output rv_pkg::word_t     wb_value
);

  rv_pkg::word_t result;
  logic [4:0]    shamt;
  logic          lt_signed;
  logic          lt_unsigned;

  assign shamt       = dec_opb[4:0];  // only the low 5 bits shift
  assign lt_signed   = $signed(dec_opa) < $signed(dec_opb);
  assign lt_unsigned = dec_opa < dec_opb;

  always_comb begin
    case (dec_op)
      rv_pkg::ALU_ADD:  result = dec_opa + dec_opb;
      rv_pkg::ALU_SUB:  result = dec_opa - dec_opb;
      rv_pkg::ALU_AND:  result = dec_opa & dec_opb;
      rv_pkg::ALU_OR:   result = dec_opa | dec_opb;
      rv_pkg::ALU_XOR:  result = dec_opa ^ dec_opb;
      rv_pkg::ALU_SLT:  result = {{31{1'b0}}, lt_signed};
      rv_pkg::ALU_SLTU: result = {{31{1'b0}}, lt_unsigned};
      rv_pkg::ALU_SLL:  result = dec_opa << shamt;
      rv_pkg::ALU_SRL:  result = dec_opa >> shamt;
      rv_pkg::ALU_SRA:  result = rv_pkg::word_t'($signed(dec_opa) >>> shamt);
      rv_pkg::ALU_LUI:  result = dec_opb;  // immediate already in the upper bits
      default:          result = '0;
    endcase
  end

  // result latch, this is also the writeback stage
  always_ff @(posedge clk) begin
    if (reset)
      wb_valid <= 1'b0;
    else
      wb_valid <= dec_valid && dec_wen && (dec_rd != '0);  // x0 writes vanish here
  end

  always_ff @(posedge clk) begin
    wb_regno <= dec_rd;
    wb_value <= result;
  end

endmodule

// File: src/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module fetch_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 load_en,
  input  rv_pkg::pc_t          load_addr,
  input  rv_pkg::inst_t        load_data,
  input  logic                 start,
  input  logic [`RV_IMEM_AW:0] prog_len,
  input  logic                 stall,
  output logic                 fetch_valid,
  output rv_pkg::inst_t        fetch_inst,
  output rv_pkg::pc_t          fetch_pc,
  output logic                 fetch_active
);

  rv_pkg::inst_t imem [`RV_IMEM_DEPTH];

  rv_pkg::fetch_state_e state;
  logic [`RV_IMEM_AW:0] issue_cnt;  // words issued so far, one wider than the pc
  logic [`RV_IMEM_AW:0] run_len;
  rv_pkg::pc_t          fetch_addr;
  logic                 launch;
  logic                 advance;
  logic                 all_issued;

  assign all_issued   = (issue_cnt == run_len);
  assign launch       = (state == rv_pkg::FETCH_IDLE) && start && (prog_len != '0);
  assign advance      = (state == rv_pkg::FETCH_RUN) && !stall && !all_issued;
  assign fetch_addr   = launch ? '0 : issue_cnt[`RV_IMEM_AW-1:0];
  assign fetch_active = (state == rv_pkg::FETCH_RUN);

  // program load port
  always_ff @(posedge clk) begin
    if (load_en)
      imem[load_addr] <= load_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= rv_pkg::FETCH_IDLE;
      fetch_valid <= 1'b0;
      issue_cnt   <= '0;
      run_len     <= '0;
    end else begin
      case (state)
        rv_pkg::FETCH_IDLE: begin
          if (launch) begin
            state       <= rv_pkg::FETCH_RUN;
            fetch_valid <= 1'b1;
            issue_cnt   <= 1;        // word 0 goes into the latch right away
            run_len     <= prog_len;
          end
        end
        rv_pkg::FETCH_RUN: begin
          if (!stall) begin
            if (all_issued) begin  // last word taken by decode
              fetch_valid <= 1'b0;
              state       <= rv_pkg::FETCH_IDLE;
            end else begin
              issue_cnt <= issue_cnt + 1'b1;
            end
          end
        end
        default: state <= rv_pkg::FETCH_IDLE;
      endcase
    end
  end

  // fetch latch payload, held while stalled
  always_ff @(posedge clk) begin
    if (launch || advance) begin
      fetch_inst <= imem[fetch_addr];
      fetch_pc   <= fetch_addr;
    end
  end

endmodule

// File: src/rv_core_top.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 load_en,
  input  rv_pkg::pc_t          load_addr,
  input  rv_pkg::inst_t        load_data,
  input  logic                 start,
  input  logic [`RV_IMEM_AW:0] prog_len,
  output logic                 wb_valid,
  output rv_pkg::regno_t       wb_regno,
  output rv_pkg::word_t        wb_value,
  output logic                 done
);

  logic            stall;
  logic            fetch_valid;
  rv_pkg::inst_t   fetch_inst;
  logic            fetch_active;
  logic            dec_valid;
  rv_pkg::alu_op_e dec_op;
  rv_pkg::regno_t  dec_rd;
  logic            dec_wen;
  rv_pkg::word_t   dec_opa;
  rv_pkg::word_t   dec_opb;
  logic            ran;  // a run has started and not yet reported done

  fetch_stage u_fetch (
    .clk          (clk),
    .reset        (reset),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .start        (start),
    .prog_len     (prog_len),
    .stall        (stall),
    .fetch_valid  (fetch_valid),
    .fetch_inst   (fetch_inst),
    .fetch_pc     (),              // pc only kept in the latch for waveforms
    .fetch_active (fetch_active)
  );

  decode_stage u_decode (
    .clk         (clk),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_inst  (fetch_inst),
    .wb_valid    (wb_valid),
    .wb_regno    (wb_regno),
    .wb_value    (wb_value),
    .stall       (stall),
    .dec_valid   (dec_valid),
    .dec_op      (dec_op),
    .dec_rd      (dec_rd),
    .dec_wen     (dec_wen),
    .dec_opa     (dec_opa),
    .dec_opb     (dec_opb)
  );

  execute_stage u_execute (
    .clk       (clk),
    .reset     (reset),
    .dec_valid (dec_valid),
    .dec_op    (dec_op),
    .dec_rd    (dec_rd),
    .dec_wen   (dec_wen),
    .dec_opa   (dec_opa),
    .dec_opb   (dec_opb),
    .wb_valid  (wb_valid),
    .wb_regno  (wb_regno),
    .wb_value  (wb_value)
  );

  // done pulses once the pipeline drains after a run
  assign done = ran && !fetch_active && !dec_valid && !wb_valid;

  always_ff @(posedge clk) begin
    if (reset)
      ran <= 1'b0;
    else if (fetch_active)
      ran <= 1'b1;
    else if (done)
      ran <= 1'b0;
  end

endmodule

// File: tb/prog_input.mem
// word 0: program length in bits 31:16, expected write count in bits 15:0
// then one instruction per line, then one expected write per line: regno value
00150013
00500093 // addi x1, x0, 5
FFD00113 // addi x2, x0, -3
002081B3 // add  x3, x1, x2   waits on x2
40208233 // sub  x4, x1, x2
001122B3 // slt  x5, x2, x1
00113333 // sltu x6, x2, x1
401153B3 // sra  x7, x2, x1
00115433 // srl  x8, x2, x1
123454B7 // lui  x9, 0x12345
6784E513 // ori  x10, x9, 0x678
FFF54593 // xori x11, x10, -1
4045D613 // srai x12, x11, 4
FFF0B693 // sltiu x13, x1, -1
00708013 // addi x0, x1, 7    no write
0000A703 // lw   x14, 0(x1)   not supported, bubble
001067B3 // or   x15, x0, x1
01C79813 // slli x16, x15, 28
0FF5F893 // andi x17, x11, 0xff
00954933 // xor  x18, x10, x9
004579B3 // and  x19, x10, x4
00109A33 // sll  x20, x1, x1
// expected writebacks in program order
01 00000005
02 FFFFFFFD
03 00000002
04 00000008
05 00000001
06 00000000
07 FFFFFFFF
08 07FFFFFF
09 12345000
0A 12345678
0B EDCBA987
0C FEDCBA98
0D 00000001
0F 00000005
10 50000000
11 00000087
12 00000678
13 00000008
14 000000A0

// File: tb/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core_tb;

  localparam int MEM_WORDS = 128;

  logic                 clk;
  logic                 reset;
  logic                 load_en;
  rv_pkg::pc_t          load_addr;
  rv_pkg::inst_t        load_data;
  logic                 start;
  logic [`RV_IMEM_AW:0] prog_len;
  logic                 wb_valid;
  rv_pkg::regno_t       wb_regno;
  rv_pkg::word_t        wb_value;
  logic                 done;

  logic [31:0] tv_mem [MEM_WORDS];  // header, program words, expected records
  int          n_prog;
  int          n_exp;
  int          rec_base;
  int          rec_idx;
  int          cycle_cnt = 0;
  int          cycle_limit;
  logic        running;
  logic        finished;

  rv_core_top dut (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .start     (start),
    .prog_len  (prog_len),
    .wb_valid  (wb_valid),
    .wb_regno  (wb_regno),
    .wb_value  (wb_value),
    .done      (done)
  );

  always #4 clk = ~clk;  // 8 ns period

  // run length guard, counts only while the program runs
  always @(posedge clk) begin
    if (running) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
        $display("timeout: done did not arrive within %0d cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $fatal(1);
      end
    end
  end

  task automatic check_regno(input string name, input rv_pkg::regno_t exp,
                             input rv_pkg::regno_t act);
    if (exp !== act) begin
      $display("Fail %s regno: expected x%0d, got x%0d", name, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic check_value(input string name, input rv_pkg::word_t exp,
                             input rv_pkg::word_t act);
    if (exp !== act) begin
      $display("Fail %s value: expected %h, got %h", name, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  // compare one writeback strobe against the next record
  task automatic take_write();
    string name;
    int    idx;
    idx = rec_base + 2 * rec_idx;
    if (rec_idx >= n_exp) begin
      $display("extra write to x%0d with %h after all %0d expected writes",
               wb_regno, wb_value, n_exp);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end else begin
      name = $sformatf("writeback %0d", rec_idx);
      check_regno(name, tv_mem[idx][`RV_REGNO_W-1:0], wb_regno);
      check_value(name, tv_mem[idx+1], wb_value);
      rec_idx++;
    end
  endtask

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    start     = 1'b0;
    prog_len  = '0;
    running   = 1'b0;
    finished  = 1'b0;
    rec_idx   = 0;

    $readmemh("tb/prog_input.mem", tv_mem);
    n_prog      = int'(tv_mem[0][31:16]);
    n_exp       = int'(tv_mem[0][15:0]);
    rec_base    = 1 + n_prog;
    cycle_limit = 4 * n_prog + 50;
    if (n_prog == 0 || n_prog > `RV_IMEM_DEPTH) begin
      $display("program length %0d in the data file is out of range", n_prog);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end

    repeat (8) @(negedge clk);
    reset = 1'b0;

    // load the program one word per cycle
    for (int i = 0; i < n_prog; i++) begin
      @(negedge clk);
      load_en   = 1'b1;
      load_addr = rv_pkg::pc_t'(i);
      load_data = tv_mem[1+i];
    end
    @(negedge clk);
    load_en = 1'b0;

    @(negedge clk);
    start    = 1'b1;
    prog_len = n_prog[`RV_IMEM_AW:0];
    running  = 1'b1;
    while (!finished) begin
      @(negedge clk);
      start = 1'b0;
      if (wb_valid)
        take_write();
      if (done)
        finished = 1'b1;
    end
    running = 1'b0;

    if (rec_idx == n_exp) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("done arrived after %0d of %0d expected writes", rec_idx, n_exp);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

endmodule
